//--- testbench/occ_cases.txt
# columns: opcode value1 value2, decimal
# W addr data | R addr expected | B code pulses | F 0 pulses | S 0 pulses
R 0 1
R 1 0
R 3 0
W 0 0
R 0 0
W 0 3
R 0 3
W 0 254
R 0 2
W 0 1
R 0 1
W 1 200
R 1 0
B 0 1
B 1 2
B 2 3
B 3 4
R 1 4
F 0 10
S 0 10
B 1 2
S 0 10
B 2 3
R 1 6

//--- filelist.f
+incdir+src
src/occ_pkg.sv
src/occ_ctl_regs.sv
src/occ_enable_logic.sv
src/occ_clk_gate.sv
src/occ_clk_mux.sv
src/occ_clk_ctlr.sv
src/occ_top.sv
testbench/occ_sva.sv
testbench/occ_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the OCC testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module occ_tb -f filelist.f -o occ_sim &&
  ./obj_dir/occ_sim ||
  { echo "OCC simulation failed"; exit 1; }

//--- testbench/occ_tb.sv
/*
  Testbench for the OCC top level. Reads operations from the case file,
  drives Wishbone accesses and scan pins on falling test_clk edges, and
  counts out_clk pulses in fixed windows to check shift, free-run and
  capture burst behavior. Stops at the first mismatch.
*/
`default_nettype none

module occ_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned SEED = 32'ha7455f57;
  localparam int CYCLES_PER_CASE = 80;
  localparam int MAX_CASES = 64;
  localparam int SETTLE_CYCLES = 6;
  localparam int BURST_WINDOW = 30;
  localparam int FREE_WINDOW = 10;
  localparam int ACK_LIMIT = 8;

  logic             test_clk;
  logic             user_clk;
  logic             rst_n;
  logic             clk_sel_n;
  logic             scan_enable;
  logic             occ_enable;
  logic             atpg_mode;
  occ_pkg::wb_req_t wb_req;
  occ_pkg::wb_rsp_t wb_rsp;
  logic             out_clk;

  // parsed case table
  logic [7:0] case_op [MAX_CASES];
  int         case_a [MAX_CASES];
  int         case_b [MAX_CASES];
  int         num_cases = 0;

  int cycle_cnt = 0;
  int cycle_limit = 0;
  bit count_en = 1'b0;
  int pulse_cnt = 0;

  occ_top occ_top_inst (
    .test_clk    (test_clk),
    .user_clk    (user_clk),
    .rst_n       (rst_n),
    .clk_sel_n   (clk_sel_n),
    .scan_enable (scan_enable),
    .occ_enable  (occ_enable),
    .atpg_mode   (atpg_mode),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .out_clk     (out_clk)
  );

  bind occ_top occ_sva occ_sva_inst (
    .test_clk   (test_clk),
    .user_clk   (user_clk),
    .rst_n      (rst_n),
    .atpg_mode  (atpg_mode),
    .occ_enable (occ_enable),
    .wb_rsp     (wb_rsp),
    .state      (occ_clk_ctlr_inst.occ_enable_logic_inst.state),
    .user_clken (occ_clk_ctlr_inst.occ_enable_logic_inst.user_clken)
  );

  initial begin
    test_clk = 1'b0;
    forever #10 test_clk = ~test_clk;
  end

  // 14 ns period keeps rising edges off every test_clk edge
  initial begin
    user_clk = 1'b0;
    forever #7 user_clk = ~user_clk;
  end

  always @(posedge out_clk) begin
    if (count_en) begin
      pulse_cnt = pulse_cnt + 1;
    end
  end

  // run length bound
  always @(posedge test_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      stop_on_failure("simulation timed out before all cases finished");
    end
  end

  task automatic stop_on_failure(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      stop_on_failure($sformatf("ERROR %s expected %0d actual %0d", name, expected, actual));
    end
  endtask

  task automatic load_cases();
    int         fd;
    int         got;
    string      line;
    logic [7:0] op;
    int         a;
    int         b;
    fd = $fopen("testbench/occ_cases.txt", "r");
    if (fd == 0) begin
      stop_on_failure("cannot open the case file testbench/occ_cases.txt");
    end
    while (!$feof(fd)) begin
      got = $fgets(line, fd);
      // skip blank and comment lines
      if (got > 0 && line.len() > 2 && line.getc(0) != "#") begin
        got = $sscanf(line, "%c %d %d", op, a, b);
        if (got != 3) begin
          stop_on_failure($sformatf("malformed case line: %s", line));
        end
        if (num_cases >= MAX_CASES) begin
          stop_on_failure("case file holds more cases than the table");
        end
        case_op[num_cases] = op;
        case_a[num_cases] = a;
        case_b[num_cases] = b;
        num_cases = num_cases + 1;
      end
    end
    $fclose(fd);
  endtask

  // classic single access with ack sampled on falling edges
  task automatic wb_access(input bit we, input int addr, input int data, output int rdata);
    int waited;
    @(negedge test_clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we = we;
    wb_req.adr = occ_pkg::occ_addr_t'(addr);
    wb_req.dat = occ_pkg::occ_data_t'(data);
    waited = 0;
    do begin
      @(negedge test_clk);
      waited = waited + 1;
      if (waited > ACK_LIMIT) begin
        stop_on_failure("register block never acked the Wishbone access");
      end
    end while (!wb_rsp.ack);
    rdata = int'(wb_rsp.dat);
    wb_req = '0;
  endtask

  // window runs between falling edges so only whole pulses count
  task automatic count_pulses(input bit on_user, input int cycles, output int n);
    if (on_user) begin
      @(negedge user_clk);
    end else begin
      @(negedge test_clk);
    end
    pulse_cnt = 0;
    count_en = 1'b1;
    repeat (cycles) begin
      if (on_user) begin
        @(posedge user_clk);
      end else begin
        @(posedge test_clk);
      end
    end
    if (on_user) begin
      @(negedge user_clk);
    end else begin
      @(negedge test_clk);
    end
    count_en = 1'b0;
    n = pulse_cnt;
  endtask

  // occ off keeps both mux chains clocked while switching
  task automatic set_clock_mode(input bit sel_n);
    @(negedge test_clk);
    clk_sel_n = sel_n;
    atpg_mode = 1'b0;
    occ_enable = 1'b0;
    scan_enable = 1'b1;
    repeat (SETTLE_CYCLES) @(negedge test_clk);
  endtask

  task automatic capture_burst(input int code, input int expected, input string name);
    int dummy;
    // mux moves to user_clk while the gate still runs free
    set_clock_mode(1'b1);
    wb_access(1'b1, 0, code, dummy);
    @(negedge test_clk);
    atpg_mode = 1'b1;
    occ_enable = 1'b1;
    // gate shuts and the sequencer arms on synced scan_enable
    repeat (2) @(negedge test_clk);
    pulse_cnt = 0;
    count_en = 1'b1;
    scan_enable = 1'b0;
    repeat (BURST_WINDOW) @(posedge user_clk);
    @(negedge test_clk);
    count_en = 1'b0;
    scan_enable = 1'b1;
    check_value(name, expected, pulse_cnt);
  endtask

  task automatic free_run_check(input int expected, input string name);
    int n;
    set_clock_mode(1'b1);
    // atpg mode without occ_enable still leaves the gate bypassed
    @(negedge test_clk);
    atpg_mode = 1'b1;
    count_pulses(1'b1, FREE_WINDOW, n);
    check_value(name, expected, n);
  endtask

  task automatic shift_clock_check(input int expected, input string name);
    int n;
    set_clock_mode(1'b0);
    count_pulses(1'b0, FREE_WINDOW, n);
    check_value(name, expected, n);
  endtask

  initial begin
    int    rdata;
    string name;
    wb_req = '0;
    rst_n = 1'b0;
    clk_sel_n = 1'b0;
    scan_enable = 1'b1;
    occ_enable = 1'b0;
    atpg_mode = 1'b0;
    void'($urandom(SEED));
    load_cases();
    if (num_cases == 0) begin
      stop_on_failure("case file holds no cases");
    end
    cycle_limit = num_cases * CYCLES_PER_CASE;
    repeat (2) @(negedge test_clk);
    rst_n = 1'b1;
    repeat (2) @(negedge test_clk);
    for (int i = 0; i < num_cases; i++) begin
      name = $sformatf("%c%0d", case_op[i], i);
      case (case_op[i])
        "W": wb_access(1'b1, case_a[i], case_b[i], rdata);
        "R": begin
          wb_access(1'b0, case_a[i], 0, rdata);
          check_value(name, case_b[i], rdata);
        end
        "B": capture_burst(case_a[i], case_b[i], name);
        "F": free_run_check(case_b[i], name);
        "S": shift_clock_check(case_b[i], name);
        default: stop_on_failure($sformatf("unknown opcode in case %0d", i));
      endcase
      // idle gap between operations
      repeat ($urandom_range(3, 0)) @(negedge test_clk);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/occ_sva.sv
/*
  Concurrent checks on the OCC top level, bound in from the testbench.
  Watches the Wishbone ack width, the user clock enable outside a burst
  and the order of the sequencer state steps.
*/
`default_nettype none

module occ_sva (
  input logic                  test_clk,
  input logic                  user_clk,
  input logic                  rst_n,
  input logic                  atpg_mode,
  input logic                  occ_enable,
  input occ_pkg::wb_rsp_t      wb_rsp,
  input occ_pkg::burst_state_t state,
  input logic                  user_clken
);
  timeunit 1ns;
  timeprecision 100ps;

  logic occ_active;

  assign occ_active = atpg_mode & occ_enable;

  // one-clock ack per classic cycle
  ack_one_cycle: assert property (
    @(posedge test_clk) disable iff (!rst_n)
    wb_rsp.ack |=> !wb_rsp.ack
  ) else $error("Wishbone ack stayed high for more than one cycle");

  // gate only opens while pulsing
  clken_off_outside_burst: assert property (
    @(posedge user_clk) disable iff (!rst_n)
    (occ_active && (state == occ_pkg::st_idle || state == occ_pkg::st_done))
      |-> !user_clken
  ) else $error("user clock enable high outside a burst in OCC mode");

  // sequencer walks idle to armed to pulsing to done and may drop back to idle
  state_step_legal: assert property (
    @(posedge user_clk) disable iff (!rst_n)
    (state != $past(state)) |-> (state == occ_pkg::st_idle
      || ($past(state) == occ_pkg::st_idle && state == occ_pkg::st_armed)
      || ($past(state) == occ_pkg::st_armed && state == occ_pkg::st_pulsing)
      || ($past(state) == occ_pkg::st_pulsing && state == occ_pkg::st_done))
  ) else $error("burst sequencer state took an illegal step");

endmodule

`default_nettype wire

//--- src/occ_top.sv
/*
  Top level of the OCC: the Wishbone register block on test_clk beside
  the clock controller it programs.
*/
`default_nettype none

module occ_top (
  input  logic             test_clk,
  input  logic             user_clk,
  input  logic             rst_n,
  input  logic             clk_sel_n,
  input  logic             scan_enable,
  input  logic             occ_enable,
  input  logic             atpg_mode,
  input  occ_pkg::wb_req_t wb_req,
  output occ_pkg::wb_rsp_t wb_rsp,
  output logic             out_clk
);

  occ_pkg::burst_code_t burst_code;
  logic                 burst_done_tgl;

  // registers, test_clk domain
  occ_ctl_regs occ_ctl_regs_inst (
    .test_clk       (test_clk),
    .rst_n          (rst_n),
    .wb_req         (wb_req),
    .wb_rsp         (wb_rsp),
    .burst_done_tgl (burst_done_tgl),
    .burst_code     (burst_code)
  );

  // clock path, burst code crosses quasi-statically
  occ_clk_ctlr occ_clk_ctlr_inst (
    .user_clk       (user_clk),
    .test_clk       (test_clk),
    .rst_n          (rst_n),
    .clk_sel_n      (clk_sel_n),
    .scan_enable    (scan_enable),
    .occ_enable     (occ_enable),
    .atpg_mode      (atpg_mode),
    .burst_code     (burst_code),
    .burst_done_tgl (burst_done_tgl),
    .out_clk        (out_clk)
  );

endmodule

`default_nettype wire

//--- src/occ_clk_ctlr.sv
/*
  Scan clock controller. Selects test_clk for shift or the gated
  user_clk for capture, and in OCC mode lets the sequencer open the
  user clock gate for one programmed burst per scan load.
*/
`default_nettype none

module occ_clk_ctlr (
  input  logic                 user_clk,
  input  logic                 test_clk,
  input  logic                 rst_n,
  input  logic                 clk_sel_n,
  input  logic                 scan_enable,
  input  logic                 occ_enable,
  input  logic                 atpg_mode,
  input  occ_pkg::burst_code_t burst_code,
  output logic                 burst_done_tgl,
  output logic                 out_clk
);

  logic clk_sel;
  logic occ_active;
  logic user_clken;
  logic int_user_clk;

  // low on the pin picks test_clk
  assign clk_sel    = ~clk_sel_n;
  assign occ_active = atpg_mode & occ_enable;

  // user clock runs free outside OCC mode
  occ_clk_gate occ_clk_gate_inst (
    .clk       (user_clk),
    .en        (user_clken),
    .tst_en    (~occ_active),
    .gated_clk (int_user_clk)
  );

  occ_enable_logic occ_enable_logic_inst (
    .user_clk       (user_clk),
    .rst_n          (rst_n),
    .scan_enable    (scan_enable),
    .occ_active     (occ_active),
    .burst_code     (burst_code),
    .user_clken     (user_clken),
    .burst_done_tgl (burst_done_tgl)
  );

  // clk1 is the shift clock
  occ_clk_mux occ_clk_mux_inst (
    .clk0    (int_user_clk),
    .clk1    (test_clk),
    .rst_n   (rst_n),
    .sel     (clk_sel),
    .clk_out (out_clk)
  );

endmodule

`default_nettype wire

//--- src/occ_clk_mux.sv
/*
  Glitch-free two-clock mux. Each clock owns an enable chain that only
  turns on once the other chain is off; the last stage moves on the
  falling edge so an enable never cuts a high phase short.
  sel low picks clk0, sel high picks clk1.
*/
`default_nettype none

module occ_clk_mux (
  input  logic clk0,
  input  logic clk1,
  input  logic rst_n,
  input  logic sel,
  output logic clk_out
);

  logic en0_a;
  logic en0_b;
  logic en1_a;
  logic en1_b;

  // clk0 side, first stage also syncs sel and the other enable
  always_ff @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      en0_a <= 1'b0;
    end else begin
      en0_a <= ~sel & ~en1_b;
    end
  end

  always_ff @(negedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      en0_b <= 1'b0;
    end else begin
      en0_b <= en0_a;
    end
  end

  // clk1 side
  always_ff @(posedge clk1 or negedge rst_n) begin
    if (!rst_n) begin
      en1_a <= 1'b0;
    end else begin
      en1_a <= sel & ~en0_b;
    end
  end

  always_ff @(negedge clk1 or negedge rst_n) begin
    if (!rst_n) begin
      en1_b <= 1'b0;
    end else begin
      en1_b <= en1_a;
    end
  end

  // enables change only while their clock is low
  assign clk_out = (clk0 & en0_b) | (clk1 & en1_b);

endmodule

`default_nettype wire

//--- src/occ_clk_gate.sv
/*
  Latch-based clock gate. The enable is captured while clk is low, so
  gated_clk never sees an enable change during the high phase.
  tst_en forces the clock through.
*/
`default_nettype none

module occ_clk_gate (
  input  logic clk,
  input  logic en,
  input  logic tst_en,
  output logic gated_clk
);

  logic en_lat;

  // transparent on the low phase
  always_latch begin
    if (!clk) begin
      en_lat <= en | tst_en;
    end
  end

  assign gated_clk = clk & en_lat;

endmodule

`default_nettype wire

//--- src/occ_enable_logic.sv
/*
  Capture burst sequencer in the user_clk domain.
  Waits for scan shift, then after scan_enable falls opens the user clock
  gate for burst code plus one cycles and flips a done toggle.
  The burst code is sampled once when the burst starts.
*/
`default_nettype none

module occ_enable_logic (
  input  logic                 user_clk,
  input  logic                 rst_n,
  input  logic                 scan_enable,
  input  logic                 occ_active,
  input  occ_pkg::burst_code_t burst_code,
  output logic                 user_clken,
  output logic                 burst_done_tgl
);

  logic                   se_meta;
  logic                   se_sync;
  occ_pkg::burst_state_t  state;
  occ_pkg::burst_code_t   pulse_cnt;

  // scan_enable is asynchronous to user_clk
  always_ff @(posedge user_clk or negedge rst_n) begin
    if (!rst_n) begin
      se_meta <= 1'b0;
      se_sync <= 1'b0;
    end else begin
      se_meta <= scan_enable;
      se_sync <= se_meta;
    end
  end

  always_ff @(posedge user_clk or negedge rst_n) begin
    if (!rst_n) begin
      state          <= occ_pkg::st_idle;
      pulse_cnt      <= '0;
      user_clken     <= 1'b0;
      burst_done_tgl <= 1'b0;
    end else if (!occ_active) begin
      // free-running mode, gate bypassed by tst_en
      state      <= occ_pkg::st_idle;
      user_clken <= 1'b0;
    end else begin
      case (state)
        occ_pkg::st_idle: begin
          // shift phase seen
          if (se_sync) begin
            state <= occ_pkg::st_armed;
          end
        end
        occ_pkg::st_armed: begin
          // capture starts, code latched here
          if (!se_sync) begin
            state      <= occ_pkg::st_pulsing;
            pulse_cnt  <= burst_code;
            user_clken <= 1'b1;
          end
        end
        occ_pkg::st_pulsing: begin
          // one pulse per cycle with clken high
          if (pulse_cnt == '0) begin
            state          <= occ_pkg::st_done;
            user_clken     <= 1'b0;
            burst_done_tgl <= ~burst_done_tgl;
          end else begin
            pulse_cnt <= pulse_cnt - 1'b1;
          end
        end
        occ_pkg::st_done: begin
          // gate held shut until next shift
          if (se_sync) begin
            state <= occ_pkg::st_idle;
          end
        end
        default: begin
          state      <= occ_pkg::st_idle;
          user_clken <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/occ_ctl_regs.sv
/*
  Wishbone classic register block on test_clk.
  CTRL at word 0 holds the burst code fed to the clock controller,
  STATUS at word 1 counts finished bursts seen on the done toggle.
  Single-cycle ack, no wait states.
*/
`default_nettype none

`include "occ_config.svh"

module occ_ctl_regs (
  input  logic                 test_clk,
  input  logic                 rst_n,
  input  occ_pkg::wb_req_t     wb_req,
  output occ_pkg::wb_rsp_t     wb_rsp,
  input  logic                 burst_done_tgl,
  output occ_pkg::burst_code_t burst_code
);

  localparam occ_pkg::occ_addr_t ADDR_CTRL   = occ_pkg::occ_addr_t'(0);
  localparam occ_pkg::occ_addr_t ADDR_STATUS = occ_pkg::occ_addr_t'(1);

  logic                 ack;
  occ_pkg::occ_data_t   rd_dat;
  occ_pkg::burst_code_t ctrl_code;
  occ_pkg::occ_data_t   status_cnt;
  logic                 req_valid;

  // done toggle crossing from user_clk
  logic tgl_meta;
  logic tgl_sync;
  logic tgl_prev;
  logic done_pulse;

  // new request, not the cycle that is already being acked
  assign req_valid = wb_req.cyc & wb_req.stb & ~ack;

  // ack for exactly one cycle per request
  always_ff @(posedge test_clk or negedge rst_n) begin
    if (!rst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= req_valid;
    end
  end

  // write lands on the same edge that raises ack
  always_ff @(posedge test_clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_code <= occ_pkg::burst_code_t'(`OCC_BURST_RST);
    end else if (req_valid && wb_req.we && wb_req.adr == ADDR_CTRL) begin
      ctrl_code <= wb_req.dat[`OCC_BURST_W-1:0];
    end
  end

  // read mux, registered with ack
  always_ff @(posedge test_clk) begin
    if (req_valid) begin
      case (wb_req.adr)
        ADDR_CTRL:   rd_dat <= occ_pkg::occ_data_t'(ctrl_code);
        ADDR_STATUS: rd_dat <= status_cnt;
        default:     rd_dat <= '0;
      endcase
    end
  end

  // two-flop sync then edge detect
  always_ff @(posedge test_clk or negedge rst_n) begin
    if (!rst_n) begin
      tgl_meta <= 1'b0;
      tgl_sync <= 1'b0;
      tgl_prev <= 1'b0;
    end else begin
      tgl_meta <= burst_done_tgl;
      tgl_sync <= tgl_meta;
      tgl_prev <= tgl_sync;
    end
  end

  assign done_pulse = tgl_sync ^ tgl_prev;

  // completed bursts, wraps at 8 bits
  always_ff @(posedge test_clk or negedge rst_n) begin
    if (!rst_n) begin
      status_cnt <= '0;
    end else if (done_pulse) begin
      status_cnt <= status_cnt + 1'b1;
    end
  end

  assign wb_rsp.ack = ack;
  assign wb_rsp.dat = rd_dat;
  assign burst_code = ctrl_code;

endmodule

`default_nettype wire

//--- src/occ_pkg.sv
/*
  Shared types of the clock controller: register vectors, the Wishbone
  request and response bundles, and the burst sequencer state encoding.
  Referenced by scoped names only.
*/
`default_nettype none

`include "occ_config.svh"

package occ_pkg;

  // register word address
  typedef logic [`OCC_ADDR_W-1:0] occ_addr_t;

  // register data word
  typedef logic [`OCC_DATA_W-1:0] occ_data_t;

  // capture pulses per burst minus one
  typedef logic [`OCC_BURST_W-1:0] burst_code_t;

  // master to slave, classic cycle
  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    occ_addr_t adr;
    occ_data_t dat;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic      ack;
    occ_data_t dat;
  } wb_rsp_t;

  // user_clk burst sequencer
  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_armed   = 2'd1,
    st_pulsing = 2'd2,
    st_done    = 2'd3
  } burst_state_t;

endpackage

`default_nettype wire

//--- src/occ_config.svh
/*
  Build-time constants of the on-chip clock controller.
  Included by the package and by any RTL file that needs a raw width or
  reset value. The package derives its typedefs from these.
*/
`ifndef OCC_CONFIG_SVH
`define OCC_CONFIG_SVH

// wishbone word address width
`define OCC_ADDR_W 2
// register data width
`define OCC_DATA_W 8
// burst code width, pulses = code + 1
`define OCC_BURST_W 2
// burst code after reset, two capture pulses
`define OCC_BURST_RST 1

`endif
